//--- hdl/lpe_macros.svh
`ifndef LPE_MACROS_SVH
`define LPE_MACROS_SVH

// Operand width on both the left and top streams
`define LPE_DATA_W 16

// Full signed product of two operands
`define LPE_PROD_W (2 * `LPE_DATA_W)

// Accumulator and result width
// 8 guard bits above the product, sum wraps modulo 2^40
`define LPE_ACC_W 40

// Encoding width shared by the control enums
`define LPE_CTRL_W 2

`endif

//--- hdl/lpe_stream_pkg.sv
`include "lpe_macros.svh"

package lpe_stream_pkg;

  // One beat on the left or top operand stream
  typedef struct packed {
    logic                          valid;
    logic                          last;
    logic signed [`LPE_DATA_W-1:0] data;
  } operand_beat_t;

  // Aligned operands, left value in a and top value in b
  typedef struct packed {
    logic                          valid;
    logic                          last_l;
    logic                          last_t;
    logic signed [`LPE_DATA_W-1:0] a;
    logic signed [`LPE_DATA_W-1:0] b;
  } operand_pair_t;

  // Dot product, valid is a one-cycle strobe
  typedef struct packed {
    logic                         valid;
    logic signed [`LPE_ACC_W-1:0] sum;
  } result_t;

endpackage

//--- hdl/lpe_ctrl_pkg.sv
`include "lpe_macros.svh"

package lpe_ctrl_pkg;

  // Vector FSM states
  // Half-arrived operands live in the aligner, not here
  typedef enum logic [`LPE_CTRL_W-1:0] {
    ST_IDLE = 2'd0,
    ST_MAC  = 2'd1,
    ST_END  = 2'd2,
    ST_ERR  = 2'd3
  } lpe_state_e;

  // Accumulator opcodes
  typedef enum logic [`LPE_CTRL_W-1:0] {
    // Keep the current sum
    MAC_HOLD = 2'd0,
    // Start a vector, sum becomes the product
    MAC_LOAD = 2'd1,
    // Sum plus product
    MAC_ACC  = 2'd2
  } mac_op_e;

endpackage

//--- hdl/operand_align.sv
`timescale 1ns/1ns
`include "lpe_macros.svh"

module operand_align
  import lpe_stream_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  operand_beat_t l_in,
  input  operand_beat_t t_in,
  input  logic          flush,
  output operand_pair_t pair
);

  // Held beat per side, flags carry the control state
  logic                          held_l_v;
  logic                          held_t_v;
  logic                          held_l_last;
  logic                          held_t_last;
  logic signed [`LPE_DATA_W-1:0] held_l_data;
  logic signed [`LPE_DATA_W-1:0] held_t_data;

  logic l_avail;
  logic t_avail;

  assign l_avail = l_in.valid || held_l_v;
  assign t_avail = t_in.valid || held_t_v;

  // A fresh beat takes precedence over the held one on the same side
  assign pair.valid  = l_avail && t_avail && !flush;
  assign pair.last_l = l_in.valid ? l_in.last : held_l_last;
  assign pair.last_t = t_in.valid ? t_in.last : held_t_last;
  assign pair.a      = l_in.valid ? l_in.data : held_l_data;
  assign pair.b      = t_in.valid ? t_in.data : held_t_data;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      held_l_v <= 1'b0;
      held_t_v <= 1'b0;
    end else if (pair.valid) begin
      // Pair consumed both sides
      held_l_v <= 1'b0;
      held_t_v <= 1'b0;
    end else begin
      if (l_in.valid) begin
        held_l_v <= 1'b1;
      end
      if (t_in.valid) begin
        held_t_v <= 1'b1;
      end
    end
  end

  // Payload only, qualified by the held flags
  always_ff @(posedge clk) begin
    if (l_in.valid) begin
      held_l_last <= l_in.last;
      held_l_data <= l_in.data;
    end
    if (t_in.valid) begin
      held_t_last <= t_in.last;
      held_t_data <= t_in.data;
    end
  end

endmodule

//--- hdl/mac_accumulator.sv
`timescale 1ns/1ns
`include "lpe_macros.svh"

module mac_accumulator
  import lpe_stream_pkg::*;
  import lpe_ctrl_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  operand_pair_t pair,
  input  mac_op_e       op,
  input  logic          emit,
  output result_t       result
);

  logic signed [`LPE_PROD_W-1:0] product;
  logic signed [`LPE_ACC_W-1:0]  product_ext;
  logic signed [`LPE_ACC_W-1:0]  acc_q;
  logic signed [`LPE_ACC_W-1:0]  acc_d;

  assign product     = pair.a * pair.b;
  assign product_ext = {{(`LPE_ACC_W - `LPE_PROD_W){product[`LPE_PROD_W-1]}}, product};

  always_comb begin
    case (op)
      MAC_LOAD: acc_d = product_ext;
      // Wraps on overflow of the guard bits
      MAC_ACC:  acc_d = acc_q + product_ext;
      default:  acc_d = acc_q;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      acc_q <= '0;
    end else begin
      acc_q <= acc_d;
    end
  end

  // Result holds its sum until the next emit
  always_ff @(posedge clk) begin
    if (rst) begin
      result.valid <= 1'b0;
      result.sum   <= '0;
    end else begin
      result.valid <= emit;
      if (emit) begin
        result.sum <= acc_d;
      end
    end
  end

endmodule

//--- hdl/lpe_control.sv
`timescale 1ns/1ns
`include "lpe_macros.svh"

module lpe_control
  import lpe_stream_pkg::*;
  import lpe_ctrl_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  operand_pair_t pair,
  output mac_op_e       op,
  output logic          emit,
  output logic          flush,
  output logic          err_misaligned
);

  lpe_state_e state_q;
  lpe_state_e state_d;

  logic misaligned;
  logic both_last;

  // Last flag comparison for the whole PE
  assign misaligned = pair.valid && (pair.last_l ^ pair.last_t);
  assign both_last  = pair.valid && pair.last_l && pair.last_t;

  assign emit = both_last;

  // Opcode from the current state
  always_comb begin
    op = MAC_HOLD;
    if (pair.valid && !misaligned) begin
      if (state_q == ST_MAC) begin
        op = MAC_ACC;
      end else begin
        // Leaving IDLE or END restarts the sum
        op = MAC_LOAD;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE, ST_MAC, ST_END: begin
        if (pair.valid) begin
          if (both_last) begin
            state_d = ST_END;
          end else if (misaligned) begin
            state_d = ST_ERR;
          end else begin
            state_d = ST_MAC;
          end
        end else if (state_q == ST_END) begin
          state_d = ST_IDLE;
        end
      end
      // One flush cycle, then start over
      ST_ERR: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= ST_IDLE;
      err_misaligned <= 1'b0;
    end else begin
      state_q        <= state_d;
      err_misaligned <= misaligned;
    end
  end

  // Aligner drops beats and held operands while in ERR
  assign flush = (state_q == ST_ERR);

endmodule

//--- hdl/lpe_top.sv
`timescale 1ns/1ns

module lpe_top
  import lpe_stream_pkg::*;
  import lpe_ctrl_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  operand_beat_t l_in,
  input  operand_beat_t t_in,
  output result_t       result,
  output logic          err_misaligned
);

  operand_pair_t pair;
  mac_op_e       op;
  logic          emit;
  logic          flush;

  operand_align u_operand_align (
    .clk   (clk),
    .rst   (rst),
    .l_in  (l_in),
    .t_in  (t_in),
    .flush (flush),
    .pair  (pair)
  );

  lpe_control u_lpe_control (
    .clk            (clk),
    .rst            (rst),
    .pair           (pair),
    .op             (op),
    .emit           (emit),
    .flush          (flush),
    .err_misaligned (err_misaligned)
  );

  mac_accumulator u_mac_accumulator (
    .clk    (clk),
    .rst    (rst),
    .pair   (pair),
    .op     (op),
    .emit   (emit),
    .result (result)
  );

endmodule

//--- verif/lpe_assert.sv
`timescale 1ns/1ns

module lpe_assert (
  input logic clk,
  input logic rst,
  input logic l_valid,
  input logic t_valid,
  input logic held_l_v,
  input logic held_t_v,
  input logic result_valid,
  input logic misaligned,
  input logic err_misaligned
);

  int violations = 0;

  // A held side waits for its partner, never for a second beat
  no_repeat_left: assert property (@(posedge clk) disable iff (rst)
    held_l_v |-> !l_valid)
    else begin
      violations++;
      $error("Second left beat arrived while a left beat was held");
    end

  no_repeat_top: assert property (@(posedge clk) disable iff (rst)
    held_t_v |-> !t_valid)
    else begin
      violations++;
      $error("Second top beat arrived while a top beat was held");
    end

  // A misaligned pair never reaches the result output
  no_result_on_misalign: assert property (@(posedge clk) disable iff (rst)
    misaligned |=> !result_valid)
    else begin
      violations++;
      $error("Result strobe followed a misaligned pair");
    end

  err_single_cycle: assert property (@(posedge clk) disable iff (rst)
    err_misaligned |=> !err_misaligned)
    else begin
      violations++;
      $error("Misalignment error held for more than one cycle");
    end

endmodule

// Reaches into the aligner and the control FSM of each PE
bind lpe_top lpe_assert u_lpe_assert (
  .clk            (clk),
  .rst            (rst),
  .l_valid        (l_in.valid),
  .t_valid        (t_in.valid),
  .held_l_v       (u_operand_align.held_l_v),
  .held_t_v       (u_operand_align.held_t_v),
  .result_valid   (result.valid),
  .misaligned     (u_lpe_control.misaligned),
  .err_misaligned (err_misaligned)
);

//--- verif/lpe_tb.sv
`timescale 1ns/1ns
`include "lpe_macros.svh"

module lpe_tb
  import lpe_stream_pkg::*;
();

  // Up to about 30 vectors of 8 pairs at 4 cycles each, plus gaps and drain
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int MAX_LEN        = 8;

  logic          clk;
  logic          rst;
  operand_beat_t l_in;
  operand_beat_t t_in;
  result_t       result;
  logic          err_misaligned;

  integer seed = 12;
  int     cycle_cnt = 0;
  int     drive_cyc;
  int     err_cnt = 0;
  int     test_err_start;
  int     pass_tests = 0;
  int     fail_tests = 0;

  logic signed [`LPE_DATA_W-1:0] vec_a [MAX_LEN];
  logic signed [`LPE_DATA_W-1:0] vec_b [MAX_LEN];

  // Expected strobes, cycle numbers as seen by the checker
  logic signed [`LPE_ACC_W-1:0] exp_sum_q [$];
  int                           exp_cyc_q [$];
  int                           err_cyc_q [$];

  lpe_top u_lpe_top (
    .clk            (clk),
    .rst            (rst),
    .l_in           (l_in),
    .t_in           (t_in),
    .result         (result),
    .err_misaligned (err_misaligned)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // Signed dot product of the first len elements, wrapped to accumulator width
  function automatic logic signed [`LPE_ACC_W-1:0] dot_ref(input int len);
    longint acc;
    acc = 0;
    for (int i = 0; i < len; i++) begin
      acc += longint'(vec_a[i]) * longint'(vec_b[i]);
    end
    return acc[`LPE_ACC_W-1:0];
  endfunction

  // Full range, with the two extremes picked more often
  function automatic logic signed [`LPE_DATA_W-1:0] rand_data();
    logic [31:0] r;
    r = $random(seed);
    if (r[4:2] == 3'd0) begin
      return {1'b1, {(`LPE_DATA_W-1){1'b0}}};
    end else if (r[4:2] == 3'd1) begin
      return {1'b0, {(`LPE_DATA_W-1){1'b1}}};
    end
    return r[31:16];
  endfunction

  function automatic int rand_range(input int limit);
    return int'({$random(seed)} % (limit + 1));
  endfunction

  task automatic fill_random(input int len);
    for (int i = 0; i < len; i++) begin
      vec_a[i] = rand_data();
      vec_b[i] = rand_data();
    end
  endtask

  task automatic drive_beats(input operand_beat_t l_beat, input operand_beat_t t_beat);
    @(posedge clk);
    l_in      <= l_beat;
    t_in      <= t_beat;
    drive_cyc = cycle_cnt;
  endtask

  // The later beat of a pair is driven lag cycles after the earlier one
  task automatic drive_pair(input int idx, input logic last_l, input logic last_t,
                            input int lag, input bit left_first);
    operand_beat_t l_beat;
    operand_beat_t t_beat;
    l_beat = '{valid: 1'b1, last: last_l, data: vec_a[idx]};
    t_beat = '{valid: 1'b1, last: last_t, data: vec_b[idx]};
    if (lag == 0) begin
      drive_beats(l_beat, t_beat);
    end else begin
      if (left_first) begin
        drive_beats(l_beat, '0);
      end else begin
        drive_beats('0, t_beat);
      end
      repeat (lag - 1) drive_beats('0, '0);
      if (left_first) begin
        drive_beats('0, t_beat);
      end else begin
        drive_beats(l_beat, '0);
      end
    end
  endtask

  task automatic send_vector(input int len, input int max_lag, input bit left_first,
                             input bit misalign);
    int   lag;
    logic last;
    for (int i = 0; i < len; i++) begin
      lag  = (max_lag == 0) ? 0 : rand_range(max_lag);
      last = (i == len - 1);
      drive_pair(i, last, last && !misalign, lag, left_first);
    end
    // Strobe is seen by the checker two edges after the final drive
    if (misalign) begin
      err_cyc_q.push_back(drive_cyc + 2);
    end else begin
      exp_sum_q.push_back(dot_ref(len));
      exp_cyc_q.push_back(drive_cyc + 2);
    end
  endtask

  task automatic start_test();
    test_err_start = err_cnt;
  endtask

  task automatic finish_test(input string name);
    int errs;
    while (exp_sum_q.size() > 0 || err_cyc_q.size() > 0) begin
      drive_beats('0, '0);
    end
    repeat (2) drive_beats('0, '0);
    errs = err_cnt - test_err_start;
    if (errs == 0) begin
      pass_tests++;
      $display("[%0t] %s: passed", $time, name);
    end else begin
      fail_tests++;
      $display("[%0t] %s: %0d errors", $time, name, errs);
    end
  endtask

  // Compares every strobe with the expected queues
  always @(posedge clk) begin
    logic signed [`LPE_ACC_W-1:0] exp_sum;
    int                           exp_cyc;
    bit                           late;
    if (!rst) begin
      if (result.valid) begin
        assert (exp_sum_q.size() > 0) else begin
          $display("ERR time=%0t signal=result.valid expected=0 actual=1", $time);
          err_cnt++;
        end
        if (exp_sum_q.size() > 0) begin
          exp_sum = exp_sum_q.pop_front();
          exp_cyc = exp_cyc_q.pop_front();
          assert (result.sum == exp_sum) else begin
            $display("ERR time=%0t signal=result.sum expected=%0d actual=%0d",
                     $time, exp_sum, result.sum);
            err_cnt++;
          end
          assert (cycle_cnt == exp_cyc) else begin
            $display("Result strobe came in cycle %0d instead of cycle %0d",
                     cycle_cnt, exp_cyc);
            err_cnt++;
          end
        end
      end else begin
        late = (exp_cyc_q.size() > 0) && (cycle_cnt > exp_cyc_q[0]);
        assert (!late) else begin
          $display("No result strobe arrived for the vector due in cycle %0d", exp_cyc_q[0]);
          err_cnt++;
        end
        if (late) begin
          exp_sum_q.delete(0);
          exp_cyc_q.delete(0);
        end
      end

      if (err_misaligned) begin
        assert (err_cyc_q.size() > 0) else begin
          $display("ERR time=%0t signal=err_misaligned expected=0 actual=1", $time);
          err_cnt++;
        end
        if (err_cyc_q.size() > 0) begin
          exp_cyc = err_cyc_q.pop_front();
          assert (cycle_cnt == exp_cyc) else begin
            $display("Misalignment error came in cycle %0d instead of cycle %0d",
                     cycle_cnt, exp_cyc);
            err_cnt++;
          end
        end
      end else begin
        late = (err_cyc_q.size() > 0) && (cycle_cnt > err_cyc_q[0]);
        assert (!late) else begin
          $display("No misalignment error arrived for the pair due in cycle %0d",
                   err_cyc_q[0]);
          err_cnt++;
        end
        if (late) begin
          err_cyc_q.delete(0);
        end
      end
    end
  end

  initial begin
    clk  = 1'b0;
    rst  = 1'b1;
    l_in = '0;
    t_in = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Outputs quiet after reset
    start_test();
    repeat (4) begin
      drive_beats('0, '0);
      assert (result.valid === 1'b0) else begin
        $display("ERR time=%0t signal=result.valid expected=0 actual=%b", $time, result.valid);
        err_cnt++;
      end
      assert (err_misaligned === 1'b0) else begin
        $display("ERR time=%0t signal=err_misaligned expected=0 actual=%b",
                 $time, err_misaligned);
        err_cnt++;
      end
    end
    finish_test("idle after reset");

    start_test();
    vec_a = '{16'sd3, -16'sd7, 16'sd1200, -16'sd32768, 16'sd0, 16'sd0, 16'sd0, 16'sd0};
    vec_b = '{16'sd5, 16'sd11, -16'sd900, -16'sd32768, 16'sd0, 16'sd0, 16'sd0, 16'sd0};
    send_vector(4, 0, 1'b1, 1'b0);
    finish_test("aligned 4-pair vector");

    // Left leads in even vectors, top leads in odd ones
    start_test();
    for (int v = 0; v < 4; v++) begin
      fill_random(5);
      send_vector(5, 3, (v % 2) == 0, 1'b0);
    end
    finish_test("skewed operands");

    // Length 1 in the middle gives adjacent result strobes
    start_test();
    fill_random(4);
    send_vector(4, 0, 1'b1, 1'b0);
    fill_random(1);
    send_vector(1, 0, 1'b1, 1'b0);
    fill_random(3);
    send_vector(3, 0, 1'b1, 1'b0);
    finish_test("back-to-back vectors");

    start_test();
    fill_random(3);
    send_vector(3, 0, 1'b1, 1'b1);
    repeat (2) drive_beats('0, '0);
    fill_random(4);
    send_vector(4, 2, 1'b0, 1'b0);
    finish_test("misaligned last flag");

    start_test();
    for (int v = 0; v < 20; v++) begin
      int len;
      len = 1 + rand_range(MAX_LEN - 1);
      fill_random(len);
      send_vector(len, 3, rand_range(1) == 1, 1'b0);
      repeat (rand_range(2)) drive_beats('0, '0);
    end
    finish_test("random regression");

    $display("Summary: %0d tests passed, %0d tests failed, %0d check errors, %0d assertion errors",
             pass_tests, fail_tests, err_cnt, u_lpe_top.u_lpe_assert.violations);
    if (fail_tests == 0 && err_cnt == 0 && u_lpe_top.u_lpe_assert.violations == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+hdl
hdl/lpe_stream_pkg.sv
hdl/lpe_ctrl_pkg.sv
hdl/operand_align.sv
hdl/mac_accumulator.sv
hdl/lpe_control.sv
hdl/lpe_top.sv
verif/lpe_assert.sv
verif/lpe_tb.sv

//--- Bender.yml
package:
  name: lpe

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lpe_stream_pkg.sv
      - hdl/lpe_ctrl_pkg.sv
      - hdl/operand_align.sv
      - hdl/mac_accumulator.sv
      - hdl/lpe_control.sv
      - hdl/lpe_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - verif/lpe_assert.sv
      - verif/lpe_tb.sv
